// ==== rv32i_types.sv ====
`default_nettype none

package rv32i_types;

	// bytes in one core word
	localparam int word_bytes = 4;

	// core-side word, used for both addresses and data
	typedef logic [31:0] rv32i_word;

	// one enable bit per byte lane of a word
	typedef logic [word_bytes-1:0] rv32i_mask;

endpackage : rv32i_types

`default_nettype wire

// ==== mem_geom_pkg.sv ====
`default_nettype none

package mem_geom_pkg;

	// byte offset inside a 32-byte line
	localparam int offset_bits = 5;

	// set index of the direct-mapped arrays
	localparam int index_bits = 3;

	// what is left of a 32-bit address
	localparam int tag_bits = 24;

	localparam int num_sets = 8;

	localparam int line_bits = 256;

	// one full cache line as it moves between levels
	typedef logic [line_bits-1:0] line_t;

	// line address, the byte address without its offset
	typedef logic [tag_bits+index_bits-1:0] line_addr_t;

endpackage : mem_geom_pkg

`default_nettype wire

// ==== mem_bus_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// line-granular request/response bus between the cache levels
interface mem_bus_if;

	logic read;
	logic write;
	mem_geom_pkg::line_addr_t addr;
	mem_geom_pkg::line_t wdata;
	mem_geom_pkg::line_t rdata;
	// one-cycle pulse that ends a request
	logic resp;

	modport requester (
		output read,
		output write,
		output addr,
		output wdata,
		input rdata,
		input resp
	);

	modport responder (
		input read,
		input write,
		input addr,
		input wdata,
		output rdata,
		output resp
	);

endinterface : mem_bus_if

`default_nettype wire

// ==== l1_cache.sv ====
`timescale 1ns/1ns
`default_nettype none

module l1_cache (
	input wire clk,
	input wire arst_n,

	// word port towards the core
	input wire read,
	input wire write,
	input wire rv32i_types::rv32i_word addr,
	input wire rv32i_types::rv32i_word wdata,
	input wire rv32i_types::rv32i_mask wmask,
	output rv32i_types::rv32i_word rdata,
	output logic resp,

	// line buses towards memory
	mem_bus_if.requester refill,
	mem_bus_if.requester writeback
);

	typedef enum logic [1:0] {
		st_idle,
		st_writeback,
		st_refill,
		st_respond
	} state_t;

	state_t state;

	logic [mem_geom_pkg::num_sets-1:0] valid;
	logic [mem_geom_pkg::num_sets-1:0] dirty;
	logic [mem_geom_pkg::tag_bits-1:0] tag_arr [mem_geom_pkg::num_sets];
	mem_geom_pkg::line_t line_arr [mem_geom_pkg::num_sets];

	logic [mem_geom_pkg::tag_bits-1:0] tag;
	logic [mem_geom_pkg::index_bits-1:0] idx;
	logic [mem_geom_pkg::offset_bits-3:0] word_sel;
	logic hit;
	logic serve;
	mem_geom_pkg::line_t cur_line;
	mem_geom_pkg::line_t merged;

	// address split
	assign tag = addr[31 -: mem_geom_pkg::tag_bits];
	assign idx = addr[mem_geom_pkg::offset_bits +: mem_geom_pkg::index_bits];
	assign word_sel = addr[mem_geom_pkg::offset_bits-1:2];

	assign cur_line = line_arr[idx];
	assign hit = valid[idx] && (tag_arr[idx] == tag);

	// a held request is skipped in the cycle its resp is visible
	assign serve = (state == st_respond) ||
		((state == st_idle) && (read || write) && hit && !resp);

	// byte merge of a store into the current line
	always_comb begin
		merged = cur_line;
		for (int b = 0; b < rv32i_types::word_bytes; b++) begin
			if (wmask[b]) begin
				merged[word_sel*32 + b*8 +: 8] = wdata[b*8 +: 8];
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			resp <= 1'b0;
			valid <= '0;
			dirty <= '0;
		end else begin
			resp <= serve;
			case (state)
				st_idle: begin
					if ((read || write) && !hit && !resp) begin
						// victim goes out first when it holds stores
						if (valid[idx] && dirty[idx]) begin
							state <= st_writeback;
						end else begin
							state <= st_refill;
						end
					end
				end
				st_writeback: begin
					if (writeback.resp) begin
						state <= st_refill;
					end
				end
				st_refill: begin
					if (refill.resp) begin
						valid[idx] <= 1'b1;
						dirty[idx] <= 1'b0;
						state <= st_respond;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
			if (serve && write) begin
				dirty[idx] <= 1'b1;
			end
		end
	end

	// tag, line and read data storage
	always_ff @(posedge clk) begin
		if ((state == st_refill) && refill.resp) begin
			line_arr[idx] <= refill.rdata;
			tag_arr[idx] <= tag;
		end else if (serve && write) begin
			line_arr[idx] <= merged;
		end
		if (serve) begin
			rdata <= cur_line[word_sel*32 +: 32];
		end
	end

	// requests follow the state, so they drop the cycle after resp
	assign writeback.read = 1'b0;
	assign writeback.write = (state == st_writeback);
	assign writeback.addr = {tag_arr[idx], idx};
	assign writeback.wdata = cur_line;

	assign refill.read = (state == st_refill);
	assign refill.write = 1'b0;
	assign refill.addr = {tag, idx};
	assign refill.wdata = '0;

	// core side keeps read and write exclusive
	assert property (@(posedge clk) disable iff (!arst_n) !(read && write));

	// the core holds its request while a miss is in flight
	assert property (@(posedge clk) disable iff (!arst_n)
		(state != st_idle) |-> (read || write));

endmodule : l1_cache

`default_nettype wire

// ==== write_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module write_buffer (
	input wire clk,
	input wire arst_n,

	// evicted lines from the data cache
	mem_bus_if.responder cache_side,

	// drain path towards the arbiter
	mem_bus_if.requester mem_side,

	// data cache refill address, checked against the held line
	input wire mem_geom_pkg::line_addr_t probe_addr,
	output logic blocked
);

	logic full;
	logic accept_resp;
	logic accept;
	mem_geom_pkg::line_addr_t buf_addr;
	mem_geom_pkg::line_t buf_line;

	// only an empty buffer takes a line
	assign accept = cache_side.write && !full && !accept_resp;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			full <= 1'b0;
			accept_resp <= 1'b0;
		end else begin
			accept_resp <= accept;
			if (accept) begin
				full <= 1'b1;
			end else if (full && mem_side.resp) begin
				full <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			buf_addr <= cache_side.addr;
			buf_line <= cache_side.wdata;
		end
	end

	assign cache_side.resp = accept_resp;
	// write-only path, nothing to return
	assign cache_side.rdata = '0;

	assign mem_side.read = 1'b0;
	assign mem_side.write = full;
	assign mem_side.addr = buf_addr;
	assign mem_side.wdata = buf_line;

	// a refill of the held line has to wait for the drain
	assign blocked = full && (probe_addr == buf_addr);

	// the data cache only ever writes into the buffer
	assert property (@(posedge clk) disable iff (!arst_n) !cache_side.read);

endmodule : write_buffer

`default_nettype wire

// ==== l1_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module l1_arbiter (
	input wire clk,
	input wire arst_n,

	// requesters, highest priority first
	mem_bus_if.responder ewb,
	mem_bus_if.responder dcache,
	mem_bus_if.responder icache,

	input wire dcache_blocked,

	// physical memory
	output logic pmem_read,
	output logic pmem_write,
	output rv32i_types::rv32i_word pmem_address,
	output mem_geom_pkg::line_t pmem_wdata,
	input wire mem_geom_pkg::line_t pmem_rdata,
	input wire pmem_resp
);

	// bit 0 ewb, bit 1 dcache, bit 2 icache
	logic [2:0] grant;
	logic [2:0] pick;
	logic idle;
	mem_geom_pkg::line_addr_t sel_addr;

	assign idle = (grant == 3'b000);

	// fixed priority choice
	always_comb begin
		if (ewb.read || ewb.write) begin
			pick = 3'b001;
		end else if ((dcache.read || dcache.write) && !dcache_blocked) begin
			pick = 3'b010;
		end else if (icache.read || icache.write) begin
			pick = 3'b100;
		end else begin
			pick = 3'b000;
		end
	end

	// grant held until memory answers
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			grant <= 3'b000;
		end else if (idle) begin
			grant <= pick;
		end else if (pmem_resp) begin
			grant <= 3'b000;
		end
	end

	always_comb begin
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		sel_addr = '0;
		pmem_wdata = '0;
		case (grant)
			3'b001: begin
				pmem_read = ewb.read;
				pmem_write = ewb.write;
				sel_addr = ewb.addr;
				pmem_wdata = ewb.wdata;
			end
			3'b010: begin
				pmem_read = dcache.read;
				pmem_write = dcache.write;
				sel_addr = dcache.addr;
				pmem_wdata = dcache.wdata;
			end
			3'b100: begin
				pmem_read = icache.read;
				pmem_write = icache.write;
				sel_addr = icache.addr;
				pmem_wdata = icache.wdata;
			end
			default: begin
			end
		endcase
	end

	// line aligned byte address
	assign pmem_address = {sel_addr, {mem_geom_pkg::offset_bits{1'b0}}};

	assign ewb.resp = grant[0] && pmem_resp;
	assign dcache.resp = grant[1] && pmem_resp;
	assign icache.resp = grant[2] && pmem_resp;

	assign ewb.rdata = pmem_rdata;
	assign dcache.rdata = pmem_rdata;
	assign icache.rdata = pmem_rdata;

	// a granted bus keeps its request until memory answers
	assert property (@(posedge clk) disable iff (!arst_n) !idle |-> (pmem_read || pmem_write));

	// the granted requester never asks for both at once
	assert property (@(posedge clk) disable iff (!arst_n) !(pmem_read && pmem_write));

endmodule : l1_arbiter

`default_nettype wire

// ==== mem_hierarchy.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_hierarchy (
	input wire clk,
	input wire arst_n,

	// port A, instruction fetch
	input wire read_a,
	input wire rv32i_types::rv32i_word address_a,
	output logic resp_a,
	output rv32i_types::rv32i_word rdata_a,

	// port B, loads and stores
	input wire read_b,
	input wire write_b,
	input wire rv32i_types::rv32i_mask wmask,
	input wire rv32i_types::rv32i_word address_b,
	input wire rv32i_types::rv32i_word wdata,
	output logic resp_b,
	output rv32i_types::rv32i_word rdata_b,

	// physical memory, whole lines
	output logic pmem_read,
	output logic pmem_write,
	output rv32i_types::rv32i_word pmem_address,
	output mem_geom_pkg::line_t pmem_wdata,
	input wire mem_geom_pkg::line_t pmem_rdata,
	input wire pmem_resp
);

	mem_bus_if icache_bus ();
	mem_bus_if dc_refill_bus ();
	mem_bus_if dc_wb_bus ();
	mem_bus_if ewb_bus ();
	// icache victim path, its lines are never dirty
	mem_bus_if ic_wb_bus ();

	logic ewb_blocked;

	assign ic_wb_bus.resp = 1'b0;
	assign ic_wb_bus.rdata = '0;

	l1_cache u_icache (
		.clk,
		.arst_n,
		.read(read_a),
		.write(1'b0),
		.addr(address_a),
		.wdata('0),
		.wmask('0),
		.rdata(rdata_a),
		.resp(resp_a),
		.refill(icache_bus),
		.writeback(ic_wb_bus)
	);

	l1_cache u_dcache (
		.clk,
		.arst_n,
		.read(read_b),
		.write(write_b),
		.addr(address_b),
		.wdata,
		.wmask,
		.rdata(rdata_b),
		.resp(resp_b),
		.refill(dc_refill_bus),
		.writeback(dc_wb_bus)
	);

	write_buffer u_ewb (
		.clk,
		.arst_n,
		.cache_side(dc_wb_bus),
		.mem_side(ewb_bus),
		.probe_addr(dc_refill_bus.addr),
		.blocked(ewb_blocked)
	);

	l1_arbiter u_arb (
		.clk,
		.arst_n,
		.ewb(ewb_bus),
		.dcache(dc_refill_bus),
		.icache(icache_bus),
		.dcache_blocked(ewb_blocked),
		.pmem_read,
		.pmem_write,
		.pmem_address,
		.pmem_wdata,
		.pmem_rdata,
		.pmem_resp
	);

endmodule : mem_hierarchy

`default_nettype wire

// ==== tb_pmem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

// behavioral line memory behind the arbiter
module tb_pmem_model (
	input wire clk,
	input wire arst_n,
	input wire pmem_read,
	input wire pmem_write,
	input wire rv32i_types::rv32i_word pmem_address,
	input wire mem_geom_pkg::line_t pmem_wdata,
	output mem_geom_pkg::line_t pmem_rdata,
	output logic pmem_resp
);

	localparam int num_lines = 64;
	localparam int log_depth = 64;

	mem_geom_pkg::line_t mem [num_lines];
	logic [31:0] wlog_addr [log_depth];
	mem_geom_pkg::line_t wlog_line [log_depth];
	int wlog_count;
	logic busy;
	int delay;
	logic [5:0] line_idx;

	assign line_idx = pmem_address[10:5];

	// every word starts as its own byte address with a fixed upper pattern
	initial begin
		for (int l = 0; l < num_lines; l++) begin
			for (int w = 0; w < 8; w++) begin
				mem[l][w*32 +: 32] = 32'(l * 32 + w * 4) ^ 32'h5a5a0000;
			end
		end
	end

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pmem_resp <= 1'b0;
			busy <= 1'b0;
			delay <= 0;
			wlog_count <= 0;
		end else if (pmem_resp) begin
			// one-cycle pulse, the grant is released meanwhile
			pmem_resp <= 1'b0;
		end else if (busy) begin
			if (delay == 0) begin
				busy <= 1'b0;
				pmem_resp <= 1'b1;
				if (pmem_write) begin
					mem[line_idx] <= pmem_wdata;
					if (wlog_count < log_depth) begin
						wlog_addr[wlog_count] <= pmem_address;
						wlog_line[wlog_count] <= pmem_wdata;
						wlog_count <= wlog_count + 1;
					end
				end else begin
					pmem_rdata <= mem[line_idx];
				end
			end else begin
				delay <= delay - 1;
			end
		end else if (pmem_read || pmem_write) begin
			busy <= 1'b1;
			delay <= int'($urandom_range(3, 0));
		end
	end

endmodule : tb_pmem_model

`default_nettype wire

// ==== tb_mem_hierarchy.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mem_hierarchy;

	localparam int num_ops = 19;
	localparam int mem_bytes = 2048;
	localparam int resp_timeout = 200;

	// one row of stimulus, port A and port B side by side
	typedef struct {
		bit a_use;
		rv32i_types::rv32i_word a_addr;
		rv32i_types::rv32i_word a_exp;
		bit b_use;
		bit b_write;
		rv32i_types::rv32i_word b_addr;
		rv32i_types::rv32i_word b_data;
		rv32i_types::rv32i_mask b_mask;
		rv32i_types::rv32i_word b_exp;
	} op_t;

	logic clk;
	logic arst_n;
	logic read_a;
	rv32i_types::rv32i_word address_a;
	logic resp_a;
	rv32i_types::rv32i_word rdata_a;
	logic read_b;
	logic write_b;
	rv32i_types::rv32i_mask wmask;
	rv32i_types::rv32i_word address_b;
	rv32i_types::rv32i_word wdata;
	logic resp_b;
	rv32i_types::rv32i_word rdata_b;
	logic pmem_read;
	logic pmem_write;
	rv32i_types::rv32i_word pmem_address;
	mem_geom_pkg::line_t pmem_wdata;
	mem_geom_pkg::line_t pmem_rdata;
	logic pmem_resp;

	op_t ops [num_ops];
	logic [7:0] ref_mem [mem_bytes];

	mem_hierarchy u_dut (
		.clk,
		.arst_n,
		.read_a,
		.address_a,
		.resp_a,
		.rdata_a,
		.read_b,
		.write_b,
		.wmask,
		.address_b,
		.wdata,
		.resp_b,
		.rdata_b,
		.pmem_read,
		.pmem_write,
		.pmem_address,
		.pmem_wdata,
		.pmem_rdata,
		.pmem_resp
	);

	tb_pmem_model u_pmem (
		.clk,
		.arst_n,
		.pmem_read,
		.pmem_write,
		.pmem_address,
		.pmem_wdata,
		.pmem_rdata,
		.pmem_resp
	);

	always #2 clk = ~clk;

	task automatic abort_run();
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	function automatic rv32i_types::rv32i_word ref_word(input rv32i_types::rv32i_word addr);
		int base;
		base = int'(addr[10:2]) * 4;
		return {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
	endfunction

	task automatic ref_write(input rv32i_types::rv32i_word addr,
		input rv32i_types::rv32i_word data, input rv32i_types::rv32i_mask mask);
		int base;
		base = int'(addr[10:2]) * 4;
		for (int b = 0; b < 4; b++) begin
			if (mask[b]) begin
				ref_mem[base+b] = data[b*8 +: 8];
			end
		end
	endtask

	// same start pattern as the memory model
	task automatic init_ref();
		logic [31:0] w;
		for (int a = 0; a < mem_bytes; a += 4) begin
			w = 32'(a) ^ 32'h5a5a0000;
			for (int b = 0; b < 4; b++) begin
				ref_mem[a+b] = w[b*8 +: 8];
			end
		end
	endtask

	task automatic run_op(input int n);
		logic pend_a;
		logic pend_b;
		int waited;
		pend_a = ops[n].a_use;
		pend_b = ops[n].b_use;
		// table values must agree with the byte model
		if (ops[n].a_use) begin
			check_eq(ref_word(ops[n].a_addr), ops[n].a_exp, $sformatf("table row %0d port A", n));
		end
		if (ops[n].b_use && !ops[n].b_write) begin
			check_eq(ref_word(ops[n].b_addr), ops[n].b_exp, $sformatf("table row %0d port B", n));
		end
		@(posedge clk);
		#1;
		read_a = ops[n].a_use;
		address_a = ops[n].a_addr;
		read_b = ops[n].b_use && !ops[n].b_write;
		write_b = ops[n].b_use && ops[n].b_write;
		address_b = ops[n].b_addr;
		wdata = ops[n].b_data;
		wmask = ops[n].b_mask;
		waited = 0;
		while (pend_a || pend_b) begin
			if (waited >= resp_timeout) begin
				if (pend_a) begin
					$display("timeout waiting for resp_a on row %0d", n);
				end else begin
					$display("timeout waiting for resp_b on row %0d", n);
				end
				abort_run();
			end else begin
				@(posedge clk);
				#1;
				waited++;
				if (pend_a && resp_a) begin
					check_eq(rdata_a, ops[n].a_exp, $sformatf("row %0d rdata_a", n));
					read_a = 1'b0;
					pend_a = 1'b0;
				end
				if (pend_b && resp_b) begin
					if (ops[n].b_write) begin
						ref_write(ops[n].b_addr, ops[n].b_data, ops[n].b_mask);
					end else begin
						check_eq(rdata_b, ops[n].b_exp, $sformatf("row %0d rdata_b", n));
					end
					read_b = 1'b0;
					write_b = 1'b0;
					pend_b = 1'b0;
				end
			end
		end
	endtask

	// latest logged write of a line has to match the byte model
	task automatic check_logged_line(input rv32i_types::rv32i_word line_addr);
		int found;
		found = -1;
		for (int i = 0; i < u_pmem.wlog_count; i++) begin
			if (u_pmem.wlog_addr[i] == line_addr) begin
				found = i;
			end
		end
		if (found < 0) begin
			$display("no memory write was logged for line %h", line_addr);
			abort_run();
		end else begin
			for (int w = 0; w < 8; w++) begin
				check_eq(u_pmem.wlog_line[found][w*32 +: 32], ref_word(line_addr + 32'(w * 4)),
					$sformatf("logged line %h word %0d", line_addr, w));
			end
		end
	endtask

	// memory port watch, every cycle
	always @(posedge clk) begin
		if (pmem_read === 1'b1 && pmem_write === 1'b1) begin
			$display("pmem_read and pmem_write were high together at %0t", $time);
			abort_run();
		end else if (arst_n !== 1'b1 && (pmem_read === 1'b1 || pmem_write === 1'b1)) begin
			$display("memory request seen during reset at %0t", $time);
			abort_run();
		end
	end

	initial begin
		void'($urandom(32'hb1aa5472));
		clk = 1'b0;
		arst_n = 1'b0;
		read_a = 1'b0;
		address_a = '0;
		read_b = 1'b0;
		write_b = 1'b0;
		wmask = '0;
		address_b = '0;
		wdata = '0;
		init_ref();
		// a_use, a_addr, a_exp, b_use, b_write, b_addr, b_data, b_mask, b_exp
		ops = '{
			'{1'b1, 32'h000, 32'h5a5a0000, 1'b0, 1'b0, 32'h0, 32'h0, 4'h0, 32'h0},
			'{1'b1, 32'h004, 32'h5a5a0004, 1'b0, 1'b0, 32'h0, 32'h0, 4'h0, 32'h0},
			'{1'b1, 32'h0a0, 32'h5a5a00a0, 1'b0, 1'b0, 32'h0, 32'h0, 4'h0, 32'h0},
			'{1'b1, 32'h7fc, 32'h5a5a07fc, 1'b0, 1'b0, 32'h0, 32'h0, 4'h0, 32'h0},
			'{1'b0, 32'h0, 32'h0, 1'b1, 1'b1, 32'h040, 32'h11223344, 4'hf, 32'h0},
			'{1'b0, 32'h0, 32'h0, 1'b1, 1'b0, 32'h040, 32'h0, 4'h0, 32'h11223344},
			'{1'b0, 32'h0, 32'h0, 1'b1, 1'b1, 32'h044, 32'haabbccdd, 4'h5, 32'h0},
			'{1'b0, 32'h0, 32'h0, 1'b1, 1'b0, 32'h044, 32'h0, 4'h0, 32'h5abb00dd},
			'{1'b0, 32'h0, 32'h0, 1'b1, 1'b1, 32'h048, 32'hdeadbeef, 4'hc, 32'h0},
			'{1'b0, 32'h0, 32'h0, 1'b1, 1'b0, 32'h048, 32'h0, 4'h0, 32'hdead0048},
			// same set as 0x040, pushes the dirty line out
			'{1'b0, 32'h0, 32'h0, 1'b1, 1'b0, 32'h140, 32'h0, 4'h0, 32'h5a5a0140},
			'{1'b0, 32'h0, 32'h0, 1'b1, 1'b0, 32'h040, 32'h0, 4'h0, 32'h11223344},
			'{1'b0, 32'h0, 32'h0, 1'b1, 1'b0, 32'h048, 32'h0, 4'h0, 32'hdead0048},
			'{1'b0, 32'h0, 32'h0, 1'b1, 1'b1, 32'h060, 32'h0badf00d, 4'hf, 32'h0},
			'{1'b0, 32'h0, 32'h0, 1'b1, 1'b0, 32'h160, 32'h0, 4'h0, 32'h5a5a0160},
			// fetch sees the store after the write-back
			'{1'b1, 32'h060, 32'h0badf00d, 1'b0, 1'b0, 32'h0, 32'h0, 4'h0, 32'h0},
			'{1'b1, 32'h020, 32'h5a5a0020, 1'b1, 1'b0, 32'h084, 32'h0, 4'h0, 32'h5a5a0084},
			'{1'b1, 32'h044, 32'h5abb00dd, 1'b1, 1'b1, 32'h088, 32'h12345678, 4'h3, 32'h0},
			'{1'b1, 32'h024, 32'h5a5a0024, 1'b1, 1'b0, 32'h088, 32'h0, 4'h0, 32'h5a5a5678}
		};
		repeat (4) @(posedge clk);
		#1;
		arst_n = 1'b1;
		for (int n = 0; n < num_ops; n++) begin
			run_op(n);
		end
		check_logged_line(32'h040);
		check_logged_line(32'h060);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule : tb_mem_hierarchy

`default_nettype wire

// ==== list.f ====
rv32i_types.sv
mem_geom_pkg.sv
mem_bus_if.sv
l1_cache.sv
write_buffer.sv
l1_arbiter.sv
mem_hierarchy.sv
tb_pmem_model.sv
tb_mem_hierarchy.sv

// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP := tb_mem_hierarchy
RTL_TOP := mem_hierarchy
FILE_LIST := list.f
LINT_FLAGS := --lint-only --timing -Wno-fatal
SIM_FLAGS := --binary --timing --assert -Wno-fatal
BUILD_DIR := obj_dir
LOG := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
